// File: design/dsp_pkg.sv
package dsp_pkg;

    // Sample stream shape
    localparam int NBITS  = 12;
    localparam int NSAMPS = 8;

    // Largest and smallest 12-bit sample
    localparam int SAMPLE_MAX = 2 ** (NBITS - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (NBITS - 1));

    // Matched filter shape
    localparam int MF_TAPS  = 42;
    localparam int MF_SHIFT = 4;
    localparam int MF_HIST  = 6;
    localparam int ACC_BITS = 18;

    // Taps grouped one block wide, then summed in pairs
    localparam int MF_GROUPS = (MF_TAPS + NSAMPS - 1) / NSAMPS;
    localparam int MF_PAIRS  = (MF_GROUPS + 1) / 2;

    // Current block plus the kept history
    localparam int WIN_LEN = (MF_HIST + 1) * NSAMPS;

    // Tap 0 weights the current sample, tap 41 the oldest
    localparam int MF_COEFFS [MF_TAPS] = '{
        -1, -1,  0,  0,  0,  1,  1,  0,
         0, -1, -1, -1,  0,  1,  1,  1,
         1,  0, -1, -1, -1,  0,  1,  2,
         1,  0, -1, -2, -2,  0,  2,  4,
         0, -4, -4,  1,  4,  1, -2, -1,
         1,  1
    };

    // Envelope widths: 2048^2 needs 23 bits, eight of them 26
    localparam int SQ_BITS  = 2 * NBITS - 1;
    localparam int POW_BITS = 26;

    typedef logic signed [NBITS-1:0]    sample_t;
    typedef sample_t [NSAMPS-1:0]       sample_block_t;
    typedef logic signed [ACC_BITS-1:0] acc_t;
    typedef logic [SQ_BITS-1:0]         sq_t;
    typedef logic [POW_BITS-1:0]        pow_t;

endpackage

// File: design/trig_pkg.sv
package trig_pkg;

    // Wishbone shape
    localparam int WB_DW = 32;
    localparam int WB_AW = 2;

    // Trigger field widths
    localparam int HOLD_BITS = 8;
    localparam int CNT_BITS  = 16;

    // Master-driven Wishbone signals
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    // Word addresses
    typedef enum logic [WB_AW-1:0] {
        REG_CTRL    = 2'd0,
        REG_THRESH  = 2'd1,
        REG_HOLDOFF = 2'd2,
        REG_COUNT   = 2'd3
    } reg_addr_e;

    typedef enum logic {
        TRIG_ARMED,
        TRIG_HOLDOFF
    } trig_state_e;

    typedef struct packed {
        logic                         enable;
        logic [dsp_pkg::POW_BITS-1:0] threshold;
        logic [HOLD_BITS-1:0]         holdoff;
    } trig_cfg_t;

    typedef struct packed {
        logic                         fire;
        logic [dsp_pkg::POW_BITS-1:0] power;
    } trig_event_t;

endpackage

// File: design/sample_delay.sv
`timescale 1ns/1ps

module sample_delay import dsp_pkg::*; #(
    parameter int DEPTH = 1
) (
    input  logic          aclk,
    input  sample_block_t din,
    output sample_block_t dout
);

    // One whole block per stage
    sample_block_t dly_q [DEPTH];

    always_ff @(posedge aclk) begin
        dly_q[0] <= din;
        for (int i = 1; i < DEPTH; i++) begin
            dly_q[i] <= dly_q[i-1];
        end
    end

    // Oldest stage out
    assign dout = dly_q[DEPTH-1];

endmodule

// File: design/matched_filter.sv
`timescale 1ns/1ps

module matched_filter import dsp_pkg::*; (
    input  logic          aclk,
    input  sample_block_t samples,
    output sample_block_t filt
);

    // hist[0] is the live block, hist[d] the block d clocks back
    sample_block_t hist [MF_HIST+1];

    // Flat sample window, index 0 is the oldest sample
    sample_t win [WIN_LEN];

    acc_t part_d [NSAMPS][MF_GROUPS];
    acc_t part_q [NSAMPS][MF_GROUPS];
    acc_t pair_q [NSAMPS][MF_PAIRS];
    acc_t sum_q  [NSAMPS];
    sample_block_t filt_q;

    // Weight one sample, coefficients are all powers of two
    function automatic acc_t tap_term(input sample_t x, input int coef);
        acc_t xe;
        xe = acc_t'(x);
        unique case (coef)
            1:       return xe;
            -1:      return -xe;
            2:       return xe <<< 1;
            -2:      return -(xe <<< 1);
            4:       return xe <<< 2;
            -4:      return -(xe <<< 2);
            default: return '0;
        endcase
    endfunction

    // Floor shift, then clamp into the 12-bit range
    function automatic sample_t sat_scale(input acc_t acc);
        acc_t sh;
        sh = acc >>> MF_SHIFT;
        if (sh > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end else if (sh < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return sample_t'(sh);
    endfunction

    assign hist[0] = samples;

    // History chain, one block per stage
    for (genvar d = 0; d < MF_HIST; d++) begin : g_hist
        sample_delay #(
            .DEPTH (1)
        ) u_dly (
            .aclk (aclk),
            .din  (hist[d]),
            .dout (hist[d+1])
        );
    end

    // Lay the blocks out oldest first
    always_comb begin
        for (int d = 0; d <= MF_HIST; d++) begin
            for (int l = 0; l < NSAMPS; l++) begin
                win[(MF_HIST - d) * NSAMPS + l] = hist[d][l];
            end
        end
    end

    // Stage 1 operands, one group of up to 8 taps per partial sum
    always_comb begin
        for (int i = 0; i < NSAMPS; i++) begin
            for (int g = 0; g < MF_GROUPS; g++) begin
                part_d[i][g] = '0;
                for (int j = g * NSAMPS; j < (g + 1) * NSAMPS && j < MF_TAPS; j++) begin
                    // Zero taps cost nothing
                    if (MF_COEFFS[j] != 0) begin
                        part_d[i][g] += tap_term(win[MF_HIST * NSAMPS + i - j], MF_COEFFS[j]);
                    end
                end
            end
        end
    end

    // Stages 1 to 4, four blocks in flight
    always_ff @(posedge aclk) begin
        part_q <= part_d;
        for (int i = 0; i < NSAMPS; i++) begin
            // Pairs of groups
            for (int p = 0; p < MF_PAIRS; p++) begin
                if (2 * p + 1 < MF_GROUPS) begin
                    pair_q[i][p] <= part_q[i][2*p] + part_q[i][2*p+1];
                end else begin
                    pair_q[i][p] <= part_q[i][2*p];
                end
            end
            // Full sum per lane
            sum_q[i] <= pair_q[i].sum();
            filt_q[i] <= sat_scale(sum_q[i]);
        end
    end

    assign filt = filt_q;

endmodule

// File: design/envelope_detector.sv
`timescale 1ns/1ps

module envelope_detector import dsp_pkg::*; (
    input  logic          aclk,
    input  sample_block_t filt,
    output pow_t          power
);

    // Full signed product per lane
    logic signed [2*NBITS-1:0] prod [NSAMPS];

    sq_t  sq_d [NSAMPS];
    sq_t  sq_q [NSAMPS];
    pow_t pow_d;
    pow_t pow_q;

    // Squares are never negative, top bit dropped
    always_comb begin
        for (int i = 0; i < NSAMPS; i++) begin
            prod[i] = filt[i] * filt[i];
            sq_d[i] = prod[i][SQ_BITS-1:0];
        end
    end

    // Block power, zero extended adds
    always_comb begin
        pow_d = '0;
        for (int i = 0; i < NSAMPS; i++) begin
            pow_d = pow_d + pow_t'(sq_q[i]);
        end
    end

    // Stage 1 squares, stage 2 sum
    always_ff @(posedge aclk) begin
        sq_q  <= sq_d;
        pow_q <= pow_d;
    end

    assign power = pow_q;

endmodule

// File: design/trigger_logic.sv
`timescale 1ns/1ps

module trigger_logic import dsp_pkg::*, trig_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  pow_t                power,
    input  trig_cfg_t           cfg,
    input  logic                count_clr,
    output trig_event_t         trig_evt,
    output logic [CNT_BITS-1:0] trig_count
);

    trig_state_e          state_q;
    logic [HOLD_BITS-1:0] hold_q;
    logic [CNT_BITS-1:0]  count_q;
    logic                 fire_d;

    // Judged on the current block only
    assign fire_d = cfg.enable && (power > cfg.threshold) && (state_q == TRIG_ARMED);

    always_ff @(posedge aclk) begin
        // Power follows the judged block
        trig_evt.power <= power;
        if (!rst_n) begin
            state_q       <= TRIG_ARMED;
            hold_q        <= '0;
            count_q       <= '0;
            trig_evt.fire <= 1'b0;
        end else begin
            trig_evt.fire <= fire_d;
            unique case (state_q)
                TRIG_ARMED: begin
                    // Zero holdoff stays armed
                    if (fire_d && cfg.holdoff != '0) begin
                        state_q <= TRIG_HOLDOFF;
                        hold_q  <= cfg.holdoff;
                    end
                end
                TRIG_HOLDOFF: begin
                    hold_q <= hold_q - 1'b1;
                    if (hold_q <= 1) begin
                        state_q <= TRIG_ARMED;
                    end
                end
            endcase
            // Clear wins over a fire in the same cycle
            if (count_clr) begin
                count_q <= '0;
            end else if (fire_d && count_q != '1) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign trig_count = count_q;

endmodule

// File: design/trig_regs.sv
`timescale 1ns/1ps

module trig_regs import dsp_pkg::*, trig_pkg::*; (
    input  logic                aclk,
    input  logic                rst_n,
    input  wb_req_t             wb_req,
    output logic [WB_DW-1:0]    wb_dat_r,
    output logic                wb_ack,
    output trig_cfg_t           cfg,
    output logic                count_clr,
    input  logic [CNT_BITS-1:0] trig_count
);

    logic             req_new;
    reg_addr_e        addr;
    logic [WB_DW-1:0] rd_data;

    // New cycle only while ack is low
    assign req_new = wb_req.cyc && wb_req.stb && !wb_ack;
    assign addr    = reg_addr_e'(wb_req.adr);

    // Read mux, fields zero extended
    always_comb begin
        unique case (addr)
            REG_CTRL:    rd_data = WB_DW'(cfg.enable);
            REG_THRESH:  rd_data = WB_DW'(cfg.threshold);
            REG_HOLDOFF: rd_data = WB_DW'(cfg.holdoff);
            REG_COUNT:   rd_data = WB_DW'(trig_count);
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            count_clr <= 1'b0;
            cfg       <= '0;
        end else begin
            wb_ack    <= req_new;
            count_clr <= req_new && wb_req.we && (addr == REG_COUNT);
            // Write lands with the ack edge
            if (req_new && wb_req.we) begin
                unique case (addr)
                    REG_CTRL:    cfg.enable    <= wb_req.dat[0];
                    REG_THRESH:  cfg.threshold <= wb_req.dat[POW_BITS-1:0];
                    REG_HOLDOFF: cfg.holdoff   <= wb_req.dat[HOLD_BITS-1:0];
                    default:     ;
                endcase
            end
        end
    end

    // Read data held while ack is high
    always_ff @(posedge aclk) begin
        if (req_new) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// File: design/trigger_chain_top.sv
`timescale 1ns/1ps

module trigger_chain_top import dsp_pkg::*, trig_pkg::*; (
    input  logic             aclk,
    input  logic             rst_n,
    input  sample_block_t    samples,
    input  wb_req_t          wb_req,
    output logic [WB_DW-1:0] wb_dat_r,
    output logic             wb_ack,
    output trig_event_t      trig_evt
);

    // Filtered stream, 4 clocks behind the input
    sample_block_t       filt;
    // One power word per block, 2 more clocks
    pow_t                power;
    trig_cfg_t           cfg;
    logic                count_clr;
    logic [CNT_BITS-1:0] trig_count;

    matched_filter u_mf (
        .aclk    (aclk),
        .samples (samples),
        .filt    (filt)
    );

    envelope_detector u_env (
        .aclk  (aclk),
        .filt  (filt),
        .power (power)
    );

    trigger_logic u_trig (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .power      (power),
        .cfg        (cfg),
        .count_clr  (count_clr),
        .trig_evt   (trig_evt),
        .trig_count (trig_count)
    );

    // Configuration and count over Wishbone
    trig_regs u_regs (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .cfg        (cfg),
        .count_clr  (count_clr),
        .trig_count (trig_count)
    );

endmodule

// File: tb/tb_mf_model.svh
`ifndef TB_MF_MODEL_SVH
`define TB_MF_MODEL_SVH

// Raw samples in stream order with the oldest first
int sample_hist[$];

// Floor by 16, then clamp to the 12-bit range
function automatic int scale_sat(input int acc);
    int sh;
    sh = acc >>> MF_SHIFT;
    if (sh > 2047) begin
        return 2047;
    end else if (sh < -2048) begin
        return -2048;
    end
    return sh;
endfunction

// Full-precision filter sum for one stream position
function automatic int filter_at(input int pos);
    int acc;
    acc = 0;
    for (int j = 0; j < MF_TAPS; j++) begin
        // Zeros were driven before the kept history
        if (pos - j >= 0) begin
            acc += MF_COEFFS[j] * sample_hist[pos - j];
        end
    end
    return acc;
endfunction

// Append one block and return its power after filtering
function automatic int push_block_power(input sample_block_t blk);
    sample_t s;
    int      base;
    int      y;
    int      pwr;
    pwr = 0;
    for (int l = 0; l < NSAMPS; l++) begin
        s = blk[l];
        sample_hist.push_back(int'(s));
    end
    base = sample_hist.size() - NSAMPS;
    for (int l = 0; l < NSAMPS; l++) begin
        y = scale_sat(filter_at(base + l));
        pwr += y * y;
    end
    // 42 taps plus one block is all the next call needs
    while (sample_hist.size() > 64) begin
        void'(sample_hist.pop_front());
    end
    return pwr;
endfunction

`endif

// File: tb/tb_trigger_chain.sv
`timescale 1ns/1ps

module tb_trigger_chain import dsp_pkg::*, trig_pkg::*; ();

    // About four times the summed length of all tests
    localparam int CYCLE_LIMIT = 2000;
    // Clocks from input block to trig_evt
    localparam int LATENCY = 7;

    typedef struct packed {
        int cycle;
        int power;
    } expect_t;

    logic             aclk;
    logic             rst_n;
    sample_block_t    samples;
    wb_req_t          wb_req;
    logic [WB_DW-1:0] wb_dat_r;
    logic             wb_ack;
    trig_event_t      trig_evt;

    // Blocks waiting to go out before the zero fill
    sample_block_t blk_q[$];
    // Expected power of each driven block tagged with its drive cycle
    expect_t       exp_q[$];
    // Cycles where the DUT fired
    int            fire_cycles[$];

    int cycle;
    bit checking;
    int errors;
    int checks;

    // Register mirror and trigger state of the model
    bit model_en;
    int model_thr;
    int model_hold;
    int model_count;
    int hold_left;

    `include "tb_mf_model.svh"

    trigger_chain_top dut (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .samples  (samples),
        .wb_req   (wb_req),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .trig_evt (trig_evt)
    );

    always #10 aclk = ~aclk;

    // Trigger rule for one block with holdoff counted in blocks
    function automatic bit judge_block(input int pwr);
        bit f;
        f = 1'b0;
        if (hold_left > 0) begin
            hold_left--;
        end else if (model_en && pwr > model_thr) begin
            f         = 1'b1;
            hold_left = model_hold;
            if (model_count < 65535) begin
                model_count++;
            end
        end
        return f;
    endfunction

    // One block per clock goes to both the DUT and the model
    always @(posedge aclk) begin
        sample_block_t blk;
        expect_t       e;
        cycle = cycle + 1;
        #1;
        if (blk_q.size() != 0) begin
            blk = blk_q.pop_front();
        end else begin
            blk = '0;
        end
        samples = blk;
        e.cycle = cycle;
        e.power = push_block_power(blk);
        exp_q.push_back(e);
    end

    // Outputs are settled at the falling edge
    always @(negedge aclk) begin
        expect_t e;
        bit      exp_fire;
        if (exp_q.size() != 0 && exp_q[0].cycle + LATENCY == cycle) begin
            e        = exp_q.pop_front();
            exp_fire = judge_block(e.power);
            if (checking) begin
                checks += 2;
                assert (trig_evt.fire === exp_fire) else begin
                    $display("FAIL t=%0t trig_evt.fire exp %0b got %0b",
                             $time, exp_fire, trig_evt.fire);
                    errors++;
                end
                assert (trig_evt.power === pow_t'(e.power)) else begin
                    $display("FAIL t=%0t trig_evt.power exp %0d got %0d",
                             $time, e.power, trig_evt.power);
                    errors++;
                end
                if (trig_evt.fire === 1'b1) begin
                    fire_cycles.push_back(cycle);
                end
            end
        end
    end

    // Watchdog
    always @(negedge aclk) begin
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run reached %0d cycles without finishing", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic wait_ack();
        do begin
            @(posedge aclk);
            #1;
        end while (wb_ack !== 1'b1);
    endtask

    // Drop the request and expect ack gone one clock later
    task automatic release_bus();
        wb_req = '0;
        @(posedge aclk);
        #1;
        checks++;
        assert (wb_ack === 1'b0) else begin
            $display("wb_ack stayed high for more than one cycle at %0t", $time);
            errors++;
        end
    endtask

    task automatic wb_read(input reg_addr_e adr, output logic [WB_DW-1:0] dat);
        @(posedge aclk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        wait_ack();
        dat = wb_dat_r;
        release_bus();
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [WB_DW-1:0] dat);
        @(posedge aclk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wait_ack();
        release_bus();
        // Mirror the register map with fields masked to their width
        case (adr)
            REG_CTRL:    model_en    = dat[0];
            REG_THRESH:  model_thr   = int'(dat[POW_BITS-1:0]);
            REG_HOLDOFF: model_hold  = int'(dat[7:0]);
            REG_COUNT:   model_count = 0;
        endcase
    endtask

    task automatic check_reg(input reg_addr_e adr, input logic [WB_DW-1:0] exp);
        logic [WB_DW-1:0] got;
        wb_read(adr, got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL t=%0t wb_dat_r(%s) exp 0x%h got 0x%h",
                     $time, adr.name(), exp, got);
            errors++;
        end
    endtask

    task automatic set_trigger(input bit en, input int thr, input int hold);
        wb_write(REG_THRESH, WB_DW'(thr));
        wb_write(REG_HOLDOFF, WB_DW'(hold));
        wb_write(REG_CTRL, WB_DW'(en));
    endtask

    task automatic queue_zeros(input int nblk);
        for (int b = 0; b < nblk; b++) begin
            blk_q.push_back('0);
        end
    endtask

    // Uniform samples in -amp..amp
    task automatic queue_noise(input int nblk, input int amp);
        sample_block_t blk;
        for (int b = 0; b < nblk; b++) begin
            for (int l = 0; l < NSAMPS; l++) begin
                blk[l] = sample_t'(int'($urandom_range(2 * amp, 0)) - amp);
            end
            blk_q.push_back(blk);
        end
    endtask

    // Random sign at amplitude 2000 so no block is quiet
    task automatic queue_strong(input int nblk);
        sample_block_t blk;
        for (int b = 0; b < nblk; b++) begin
            for (int l = 0; l < NSAMPS; l++) begin
                blk[l] = ($urandom() % 2 != 0) ? sample_t'(2000) : sample_t'(-2000);
            end
            blk_q.push_back(blk);
        end
    endtask

    // One sample at one lane, then enough zeros to leave all 42 taps
    task automatic queue_impulse(input int lane);
        sample_block_t blk;
        blk       = '0;
        blk[lane] = sample_t'(1000);
        blk_q.push_back(blk);
        queue_zeros(6);
    endtask

    // Time-reversed taps at 511 per unit drive the peak sum far above 12 bits
    task automatic queue_pulse();
        sample_block_t blk;
        int            m;
        for (int b = 0; b < 6; b++) begin
            for (int l = 0; l < NSAMPS; l++) begin
                m = b * NSAMPS + l;
                if (m < MF_TAPS) begin
                    blk[l] = sample_t'(511 * MF_COEFFS[MF_TAPS - 1 - m]);
                end else begin
                    blk[l] = '0;
                end
            end
            blk_q.push_back(blk);
        end
        queue_zeros(6);
    endtask

    // Filter tail plus pipeline latency
    task automatic wait_drained();
        while (blk_q.size() != 0) begin
            @(posedge aclk);
        end
        repeat (16) @(posedge aclk);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int err0;
        aclk        = 1'b0;
        rst_n       = 1'b0;
        samples     = '0;
        wb_req      = '0;
        cycle       = 0;
        checking    = 1'b0;
        errors      = 0;
        checks      = 0;
        model_en    = 1'b0;
        model_thr   = 0;
        model_hold  = 0;
        model_count = 0;
        hold_left   = 0;
        void'($urandom(32'h2523));
        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        // Zeros flush the unreset filter history first
        repeat (10) @(posedge aclk);
        checking = 1'b1;

        // Reset values, then masked readback
        err0 = errors;
        check_reg(REG_CTRL, '0);
        check_reg(REG_THRESH, '0);
        check_reg(REG_HOLDOFF, '0);
        check_reg(REG_COUNT, '0);
        wb_write(REG_CTRL, 32'hffff_ffff);
        wb_write(REG_THRESH, 32'hffff_ffff);
        wb_write(REG_HOLDOFF, 32'h1234_56a5);
        check_reg(REG_CTRL, 32'h0000_0001);
        check_reg(REG_THRESH, 32'h03ff_ffff);
        check_reg(REG_HOLDOFF, 32'h0000_00a5);
        finish_test("register access", err0);

        // Impulse per lane, then the matched pulse
        err0 = errors;
        set_trigger(1'b1, 0, 0);
        fire_cycles.delete();
        for (int l = 0; l < NSAMPS; l++) begin
            queue_impulse(l);
        end
        wait_drained();
        checks++;
        assert (fire_cycles.size() > 0) else begin
            $display("impulses produced no trigger at all");
            errors++;
        end
        queue_pulse();
        wait_drained();
        finish_test("impulse and matched pulse", err0);

        // Full-range noise with every block judged
        err0 = errors;
        queue_noise(150, 2047);
        wait_drained();
        finish_test("random noise", err0);

        // Small noise stays under 8 * 93^2 while the pulse goes far above
        err0 = errors;
        set_trigger(1'b1, 100000, 0);
        fire_cycles.delete();
        queue_noise(20, 31);
        queue_pulse();
        queue_noise(20, 31);
        wait_drained();
        checks++;
        assert (fire_cycles.size() > 0) else begin
            $display("pulse above threshold did not trigger");
            errors++;
        end
        finish_test("threshold", err0);

        // Holdoff 3 gives one fire every fourth block
        err0 = errors;
        set_trigger(1'b1, 0, 3);
        fire_cycles.delete();
        queue_strong(40);
        wait_drained();
        checks++;
        assert (fire_cycles.size() >= 10) else begin
            $display("only %0d fires under a sustained signal", fire_cycles.size());
            errors++;
        end
        for (int i = 1; i < 10 && i < fire_cycles.size(); i++) begin
            checks++;
            assert (fire_cycles[i] - fire_cycles[i-1] == 4) else begin
                $display("FAIL t=%0t trig_evt.fire spacing exp 4 got %0d",
                         $time, fire_cycles[i] - fire_cycles[i-1]);
                errors++;
            end
        end
        check_reg(REG_COUNT, WB_DW'(model_count));
        wb_write(REG_COUNT, 32'h0000_0001);
        check_reg(REG_COUNT, '0);
        finish_test("holdoff and count", err0);

        // A strong signal while disabled leaves no trace
        err0 = errors;
        wb_write(REG_CTRL, '0);
        fire_cycles.delete();
        queue_strong(40);
        wait_drained();
        checks++;
        assert (fire_cycles.size() == 0) else begin
            $display("trigger fired %0d times while disabled", fire_cycles.size());
            errors++;
        end
        check_reg(REG_COUNT, WB_DW'(model_count));
        finish_test("disable", err0);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tb
design/dsp_pkg.sv
design/trig_pkg.sv
design/sample_delay.sv
design/matched_filter.sv
design/envelope_detector.sv
design/trigger_logic.sv
design/trig_regs.sv
design/trigger_chain_top.sv
tb/tb_trigger_chain.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_trigger_chain -f vlog.f
./obj_dir/Vtb_trigger_chain > sim.log
cat sim.log

if grep -q "TEST PASS" sim.log; then
    exit 0
else
    exit 1
fi
